// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_mips
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/mips_props.sv
//##########################################################################
// bound assertions on fetch address and retire behavior
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module mips_props import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  word_t   imem_addr,
    input  word_t   d_instr,
    input  logic    stall,
    input  retire_t retire
);

    logic  branch_in_decode;
    word_t branch_offset;

    assign branch_in_decode = (d_instr[31:26] == op_beq) || (d_instr[31:26] == op_bne);
    assign branch_offset    = {{14{d_instr[15]}}, d_instr[15:0], 2'b00};

    // fetch steps by one word without a stall or a branch in decode
    pc_sequential: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        !branch_in_decode && !stall |=> imem_addr == $past(imem_addr) + pc_step)
        else $error("fetch address did not step by one word");

    pc_hold_in_stall: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        stall |=> imem_addr == $past(imem_addr))
        else $error("fetch address moved during a stall");

    // pc already points one word past the branch
    pc_branch: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        branch_in_decode |=> (imem_addr == $past(imem_addr)) ||
                             (imem_addr == $past(imem_addr) + pc_step) ||
                             (imem_addr == $past(imem_addr) + $past(branch_offset)))
        else $error("fetch address after a branch is not a legal target");

    retire_quiet_in_reset: assert property (@(posedge SYS_clk)
        SYS_reset |=> !retire.valid)
        else $error("retire strobe right after reset");

    retire_known: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        retire.valid |-> !$isunknown(retire.data) && retire.addr != '0)
        else $error("retire carries an unknown value or register zero");

endmodule

bind mips_pipeline mips_props props0 (
    .SYS_clk   (SYS_clk),
    .SYS_reset (SYS_reset),
    .imem_addr (imem_addr),
    .d_instr   (d_instr),
    .stall     (stall),
    .retire    (retire)
);

`default_nettype wire

// File: dv/tb_clock.sv
//##########################################################################
// testbench clock and synchronous reset generator
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module tb_clock
(
    output logic SYS_clk,
    output logic SYS_reset
);

    localparam int half_period  = 50;  // 100 ns clock
    localparam int reset_cycles = 8;

    initial
    begin
        SYS_clk = 1'b0;
        forever #half_period SYS_clk = ~SYS_clk;
    end

    initial
    begin
        SYS_reset = 1'b1;
        repeat (reset_cycles) @(posedge SYS_clk);
        SYS_reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: dv/tb_mips.sv
//##########################################################################
// testbench top: instruction memory, program, reference model
// and retire checking against the model
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module tb_mips import mips_pkg::*;
();

    localparam int prog_words         = 64;
    localparam int first_retire_cycle = 4;  // fetch to write-back
    localparam int reset_limit        = 20;
    localparam int run_limit          = 300;
    localparam int drain_cycles       = 8;

    logic    SYS_clk;
    logic    SYS_reset;
    word_t   imem_addr;
    word_t   imem_data;
    retire_t retire;

    word_t   prog [prog_words];
    int      prog_len = 0;
    word_t   rng_state;
    retire_t exp_q [$];
    retire_t want;
    int      retired = 0;
    int      cycle = 0;

    tb_clock clock0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset)
    );

    mips_pipeline dut0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .retire    (retire)
    );

    // fetches past the array read nops
    assign imem_data = (imem_addr < word_t'(prog_words * 4)) ? prog[imem_addr[7:2]] : '0;

    function automatic word_t xorshift32(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic word_t next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic word_t rtype_word(logic [5:0] funct, int rd, int rs, int rt);
        return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
    endfunction

    function automatic word_t itype_word(logic [5:0] op, int rt, int rs, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic append_instr(word_t w);
        prog[6'(prog_len)] = w;
        prog_len++;
    endtask

    task automatic report_mismatch(string name, word_t got, word_t expected);
        $display("Fail %s: got 0x%08h expected 0x%08h at retire %0d",
                 name, got, expected, retired);
        $display("Verification failed");
        $fatal(1, "retire mismatch");
    endtask

    task automatic abort_run(string reason);
        $display("Error: %s", reason);
        $display("Verification failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_words; i++)
            prog[6'(i)] = '0;
        rng_state = 32'hb7a9;
        for (int r = 1; r <= 4; r++)
            append_instr(itype_word(op_addi, r, 0, next_random()));  // register seeds
        append_instr(rtype_word(funct_add, 5, 1, 2));
        append_instr(rtype_word(funct_sub, 6, 3, 1));
        append_instr(rtype_word(funct_and, 7, 1, 3));
        append_instr(rtype_word(funct_or, 8, 2, 4));
        append_instr(rtype_word(funct_slt, 9, 1, 2));
        append_instr(rtype_word(funct_add, 11, 5, 6));  // dependent chain
        append_instr(rtype_word(funct_sub, 12, 11, 1));
        append_instr(rtype_word(funct_or, 13, 12, 11));
        append_instr(rtype_word(funct_slt, 14, 13, 12));
        append_instr(itype_word(op_addi, 15, 14, next_random()));
        append_instr(itype_word(op_addi, 10, 0, 16));  // data base address
        append_instr(itype_word(op_sw, 5, 10, 8));
        append_instr(itype_word(op_lw, 16, 10, 8));  // load of the stored word
        append_instr(rtype_word(funct_add, 17, 16, 1));  // load use
        append_instr(itype_word(op_sw, 17, 0, 0));
        append_instr(itype_word(op_lw, 18, 0, 0));
        append_instr(itype_word(op_sw, 18, 10, 4));  // load feeds store data
        append_instr(itype_word(op_lw, 19, 10, 4));
        append_instr(rtype_word(funct_add, 20, 1, 0));
        append_instr(itype_word(op_beq, 20, 1, 1));  // taken, alu to branch
        append_instr(itype_word(op_addi, 21, 0, 1));
        append_instr(itype_word(op_bne, 2, 1, 2));  // taken
        append_instr(itype_word(op_addi, 22, 0, 2));
        append_instr(itype_word(op_addi, 23, 0, 3));
        append_instr(itype_word(op_beq, 2, 1, 1));  // not taken
        append_instr(itype_word(op_addi, 24, 1, next_random()));
        append_instr(itype_word(op_bne, 1, 20, 1));  // not taken
        append_instr(itype_word(op_lw, 25, 10, 8));
        append_instr(itype_word(op_beq, 16, 25, 1));  // taken, load to branch
        append_instr(itype_word(op_addi, 26, 0, 4));
        append_instr(rtype_word(funct_add, 27, 25, 24));
        append_instr(itype_word(op_lw, 28, 10, 4));
        append_instr(rtype_word(funct_add, 29, 1, 2));
        append_instr(rtype_word(funct_add, 30, 28, 1));  // load two ahead of its use
    endtask

    // in-order execution of the program, one retire per register write
    task automatic run_model();
        word_t     ref_regs [num_regs];
        word_t     ref_mem [dmem_words];
        word_t     pc;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     imm;
        word_t     addr;
        word_t     res;
        reg_addr_t dst;
        logic      writes;
        int        steps;
        retire_t   r;
        for (int i = 0; i < num_regs; i++)
            ref_regs[5'(i)] = '0;
        pc    = '0;
        steps = 0;
        while (pc < word_t'(prog_len * 4) && steps < run_limit)
        begin
            ins    = prog[pc[7:2]];
            a      = ref_regs[ins[25:21]];
            b      = ref_regs[ins[20:16]];
            imm    = {{16{ins[15]}}, ins[15:0]};
            addr   = a + imm;
            dst    = ins[20:16];
            res    = '0;
            writes = 1'b1;
            pc     = pc + pc_step;
            case (ins[31:26])
                op_rtype:
                begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        funct_add: res = a + b;
                        funct_sub: res = a - b;
                        funct_and: res = a & b;
                        funct_or:  res = a | b;
                        funct_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:   writes = 1'b0;
                    endcase
                end
                op_addi: res = addr;
                op_lw:   res = ref_mem[addr[dmem_aw+1:2]];
                op_sw:
                begin
                    ref_mem[addr[dmem_aw+1:2]] = b;
                    writes = 1'b0;
                end
                op_beq, op_bne:
                begin
                    writes = 1'b0;
                    if ((a == b) == (ins[31:26] == op_beq))  // beq on equal, bne otherwise
                        pc = pc + {imm[29:0], 2'b00};
                end
                default: writes = 1'b0;
            endcase
            if (writes)
            begin
                if (dst != '0)
                    ref_regs[dst] = res;
                r.valid = 1'b1;
                r.addr  = dst;
                r.data  = res;
                exp_q.push_back(r);
            end
            steps++;
        end
    endtask

    // outputs settle between edges
    always @(negedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            assert (!retire.valid) else abort_run("retire strobe during reset");
        end
        else
        begin
            if (cycle == 0)
                assert (imem_addr == '0) else report_mismatch("imem_addr", imem_addr, '0);
            if (retire.valid)
            begin
                assert (retired < exp_q.size())
                    else abort_run("retire strobe beyond the end of the program");
                want = exp_q[retired];
                assert (retired != 0 || cycle == first_retire_cycle)
                    else abort_run("first retire strobe at the wrong cycle");
                assert (retire.addr == want.addr)
                    else report_mismatch("retire.addr", 32'(retire.addr), 32'(want.addr));
                assert (retire.data == want.data)
                    else report_mismatch("retire.data", retire.data, want.data);
                retired++;
            end
            cycle++;
        end
    end

    initial
    begin
        int waited;
        load_program();
        run_model();
        waited = 0;
        do
        begin
            @(posedge SYS_clk);
            waited++;
        end
        while (SYS_reset && waited < reset_limit);
        if (SYS_reset)
            abort_run("reset was never released");
        waited = 0;
        while (retired < exp_q.size() && waited < run_limit)
        begin
            @(posedge SYS_clk);
            waited++;
        end
        for (int i = 0; i < drain_cycles; i++)
            @(posedge SYS_clk);  // no stray retire after the last one
        if (retired == exp_q.size())
        begin
            $display("Verification passed");
            $finish;
        end
        else
            abort_run("timeout waiting for the final retire strobe");
    end

endmodule

`default_nettype wire

// File: hdl/decode_stage.sv
//##########################################################################
// pc and decode register, control decode, operand forwarding
// and branch resolution in decode
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module decode_stage import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  word_t   imem_data,
    output word_t   imem_addr,
    input  logic    stall,
    input  logic    fwd_rs,
    input  logic    fwd_rt,
    input  word_t   mem_result,
    input  retire_t wb,
    output word_t   d_instr,
    output id_ex_t  id_ex
);

    word_t pc_q;
    word_t d_pc_q;
    ctrl_t ctrl;
    word_t rs_reg;
    word_t rt_reg;
    word_t rs_val;
    word_t rt_val;
    word_t imm;
    word_t branch_target;
    logic  operands_equal;
    logic  branch_taken;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            pc_q <= '0;
        else if (!stall)
        begin
            if (branch_taken)
                pc_q <= branch_target;
            else
                pc_q <= pc_q + pc_step;
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            d_instr <= '0;
        else if (!stall)
            d_instr <= branch_taken ? '0 : imem_data;  // kill fetch behind taken branch
    end

    always_ff @(posedge SYS_clk)
    begin
        if (!stall)
            d_pc_q <= pc_q;
    end

    assign imem_addr = pc_q;

    always_comb
    begin
        ctrl = '0;
        case (d_instr[31:26])
            op_rtype:
            begin
                ctrl.reg_write = (d_instr != '0);  // all-zero word is a nop
                ctrl.reg_dst   = 1'b1;
                ctrl.alu_op    = aluop_funct;
            end
            op_addi:
            begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            op_lw:
            begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            op_sw:
            begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            op_beq, op_bne:
            begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = aluop_sub;
            end
            default: ;
        endcase
    end

    register_file regs0 (
        .SYS_clk (SYS_clk),
        .rs_addr (d_instr[25:21]),
        .rt_addr (d_instr[20:16]),
        .wr      (wb),
        .rs_data (rs_reg),
        .rt_data (rt_reg)
    );

    assign rs_val = fwd_rs ? mem_result : rs_reg;
    assign rt_val = fwd_rt ? mem_result : rt_reg;
    assign imm    = {{16{d_instr[15]}}, d_instr[15:0]};

    assign operands_equal = (rs_val == rt_val);
    assign branch_target  = d_pc_q + pc_step + {imm[29:0], 2'b00};
    assign branch_taken   = ctrl.branch && !stall &&
                            ((d_instr[31:26] == op_beq && operands_equal) ||
                             (d_instr[31:26] == op_bne && !operands_equal));

    always_comb
    begin
        if (stall)
            id_ex = '0;  // bubble into execute
        else
        begin
            id_ex.instr  = d_instr;
            id_ex.ctrl   = ctrl;
            id_ex.rs_val = rs_val;
            id_ex.rt_val = rt_val;
            id_ex.imm    = imm;
            id_ex.dst    = ctrl.reg_dst ? d_instr[15:11] : d_instr[20:16];
        end
    end

endmodule

`default_nettype wire

// File: hdl/execute_stage.sv
//##########################################################################
// execute register, alu control and alu
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module execute_stage import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    id_ex_t    ex_q;
    alu_ctrl_t alu_ctrl;
    word_t     op_b;
    word_t     result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            ex_q <= '0;
        else
            ex_q <= id_ex;
    end

    always_comb
    begin
        case (ex_q.ctrl.alu_op)
            aluop_add: alu_ctrl = alu_add;
            aluop_sub: alu_ctrl = alu_sub;
            default:
            begin
                case (ex_q.instr[5:0])
                    funct_sub: alu_ctrl = alu_sub;
                    funct_and: alu_ctrl = alu_and;
                    funct_or:  alu_ctrl = alu_or;
                    funct_slt: alu_ctrl = alu_slt;
                    default:   alu_ctrl = alu_add;  // funct_add
                endcase
            end
        endcase
    end

    assign op_b = ex_q.ctrl.alu_src ? ex_q.imm : ex_q.rt_val;

    always_comb
    begin
        case (alu_ctrl)
            alu_sub: result = ex_q.rs_val - op_b;
            alu_and: result = ex_q.rs_val & op_b;
            alu_or:  result = ex_q.rs_val | op_b;
            alu_slt: result = ($signed(ex_q.rs_val) < $signed(op_b)) ? 32'd1 : 32'd0;
            default: result = ex_q.rs_val + op_b;
        endcase
    end

    assign ex_mem.instr      = ex_q.instr;
    assign ex_mem.ctrl       = ex_q.ctrl;
    assign ex_mem.alu_result = result;
    assign ex_mem.store_data = ex_q.rt_val;  // forwarded in decode already
    assign ex_mem.dst        = ex_q.dst;

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
//##########################################################################
// stall counter and memory-to-decode forward selects
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module hazard_unit import mips_pkg::*;
(
    input  logic  SYS_clk,
    input  logic  SYS_reset,
    input  word_t d_instr,
    input  word_t ex_instr,
    input  word_t mem_instr,
    output logic  stall,
    output logic  fwd_rs,
    output logic  fwd_rt
);

    logic [1:0] count_q;
    logic [1:0] count_now;
    logic       hit_ex;
    logic       hit_mem;
    reg_addr_t  mem_dst;

    function automatic reg_addr_t dest_of(word_t i);
        return (i[31:26] == op_rtype) ? i[15:11] : i[20:16];  // rd or rt
    endfunction

    function automatic logic writes_alu(word_t i);
        return (i[31:26] == op_rtype && i != '0) || i[31:26] == op_addi;
    endfunction

    function automatic logic reads_reg(word_t i, reg_addr_t r);
        logic rt_used;
        rt_used = i[31:26] inside {op_rtype, op_beq, op_bne, op_sw};
        return r != '0 && (i[25:21] == r || (rt_used && i[20:16] == r));
    endfunction

    assign hit_ex  = reads_reg(d_instr, dest_of(ex_instr));
    assign hit_mem = reads_reg(d_instr, dest_of(mem_instr));
    assign mem_dst = dest_of(mem_instr);

    always_comb
    begin
        if (count_q != '0)  // still draining a stall
            count_now = count_q;
        else if (ex_instr[31:26] == op_lw && hit_ex)
            count_now = stall_load;
        else if (writes_alu(ex_instr) && hit_ex)
            count_now = stall_alu;
        else if (mem_instr[31:26] == op_lw && hit_mem)  // load one slot further on
            count_now = stall_alu;
        else
            count_now = '0;
    end

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            count_q <= '0;
        else if (count_now != '0)
            count_q <= count_now - 2'd1;
    end

    assign stall = (count_now != '0);

    // only alu results exist in memory, load data comes later
    assign fwd_rs = writes_alu(mem_instr) && mem_dst != '0 && mem_dst == d_instr[25:21];
    assign fwd_rt = writes_alu(mem_instr) && mem_dst != '0 && mem_dst == d_instr[20:16];

endmodule

`default_nettype wire

// File: hdl/memory_writeback_stage.sv
//##########################################################################
// memory register, data memory, write-back register and result select
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module memory_writeback_stage import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  ex_mem_t ex_mem,
    output word_t   mem_result,
    output word_t   mem_instr,
    output retire_t retire
);

    ex_mem_t            mem_q;
    word_t              dmem [dmem_words];
    logic [dmem_aw-1:0] dmem_idx;
    word_t              load_data;
    retire_t            wb_q;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            mem_q <= '0;
        else
            mem_q <= ex_mem;
    end

    assign dmem_idx = mem_q.alu_result[dmem_aw+1:2];  // word index

    always_ff @(posedge SYS_clk)
    begin
        if (mem_q.ctrl.mem_write)
            dmem[dmem_idx] <= mem_q.store_data;
    end

    assign load_data = mem_q.ctrl.mem_read ? dmem[dmem_idx] : '0;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            wb_q <= '0;
        else
        begin
            wb_q.valid <= mem_q.ctrl.reg_write;
            wb_q.addr  <= mem_q.dst;
            wb_q.data  <= mem_q.ctrl.mem_to_reg ? load_data : mem_q.alu_result;
        end
    end

    assign mem_result = mem_q.alu_result;
    assign mem_instr  = mem_q.instr;
    assign retire     = wb_q;  // also the register file write

endmodule

`default_nettype wire

// File: hdl/mips_pipeline.sv
//##########################################################################
// five-stage pipeline top, stage and hazard unit wiring
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module mips_pipeline import mips_pkg::*;
(
    input  logic    SYS_clk,
    input  logic    SYS_reset,
    input  word_t   imem_data,
    output word_t   imem_addr,
    output retire_t retire
);

    logic    stall;
    logic    fwd_rs;
    logic    fwd_rt;
    word_t   d_instr;
    word_t   mem_result;
    word_t   mem_instr;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;

    hazard_unit hazard0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .d_instr   (d_instr),
        .ex_instr  (ex_mem.instr),
        .mem_instr (mem_instr),
        .stall     (stall),
        .fwd_rs    (fwd_rs),
        .fwd_rt    (fwd_rt)
    );

    decode_stage decode0 (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .stall      (stall),
        .fwd_rs     (fwd_rs),
        .fwd_rt     (fwd_rt),
        .mem_result (mem_result),
        .wb         (retire),
        .d_instr    (d_instr),
        .id_ex      (id_ex)
    );

    execute_stage execute0 (
        .SYS_clk   (SYS_clk),
        .SYS_reset (SYS_reset),
        .id_ex     (id_ex),
        .ex_mem    (ex_mem)
    );

    memory_writeback_stage memwb0 (
        .SYS_clk    (SYS_clk),
        .SYS_reset  (SYS_reset),
        .ex_mem     (ex_mem),
        .mem_result (mem_result),
        .mem_instr  (mem_instr),
        .retire     (retire)
    );

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
//##########################################################################
// widths, opcode and function codes, alu selects
// control word and pipeline register structs
//##########################################################################
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_ctrl_t;

    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_addi  = 6'h08;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;

    localparam logic [5:0] funct_add = 6'h20;
    localparam logic [5:0] funct_sub = 6'h22;
    localparam logic [5:0] funct_and = 6'h24;
    localparam logic [5:0] funct_or  = 6'h25;
    localparam logic [5:0] funct_slt = 6'h2a;

    localparam int         num_regs   = 32;
    localparam int         dmem_words = 64;
    localparam int         dmem_aw    = $clog2(dmem_words);
    localparam logic [1:0] stall_load = 2'd2;  // load data lands in write-back
    localparam logic [1:0] stall_alu  = 2'd1;  // result reachable by forwarding
    localparam word_t      pc_step    = 32'd4;

    localparam logic [1:0] aluop_add   = 2'b00;  // lw, sw, addi
    localparam logic [1:0] aluop_sub   = 2'b01;  // branches
    localparam logic [1:0] aluop_funct = 2'b10;  // r-type, from funct

    localparam alu_ctrl_t alu_and = 4'b0000;
    localparam alu_ctrl_t alu_or  = 4'b0001;
    localparam alu_ctrl_t alu_add = 4'b0010;
    localparam alu_ctrl_t alu_sub = 4'b0110;
    localparam alu_ctrl_t alu_slt = 4'b0111;

    typedef struct packed {
        logic       reg_write;
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic       alu_src;
        logic       reg_dst;
        logic       branch;
        logic [1:0] alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t     instr;
        ctrl_t     ctrl;
        word_t     rs_val;
        word_t     rt_val;
        word_t     imm;
        reg_addr_t dst;
    } id_ex_t;

    typedef struct packed {
        word_t     instr;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

// File: hdl/register_file.sv
//##########################################################################
// register file, two read ports and one write port with write-through
//##########################################################################
`timescale 1ns/10ps
`default_nettype none

module register_file import mips_pkg::*;
(
    input  logic      SYS_clk,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  retire_t   wr,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [num_regs];

    always_ff @(posedge SYS_clk)
    begin
        if (wr.valid && wr.addr != '0)  // r0 stays zero
            regs[wr.addr] <= wr.data;
    end

    // same-cycle write is visible to decode
    assign rs_data = (rs_addr == '0) ? '0 :
                     (wr.valid && wr.addr == rs_addr) ? wr.data : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 :
                     (wr.valid && wr.addr == rt_addr) ? wr.data : regs[rt_addr];

endmodule

`default_nettype wire

// File: project.f
hdl/mips_pkg.sv
hdl/register_file.sv
hdl/hazard_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_writeback_stage.sv
hdl/mips_pipeline.sv
dv/tb_clock.sv
dv/mips_props.sv
dv/tb_mips.sv
